// ==== cache_ctrl.f ====
logic/cache_pkg.sv
logic/way_if.sv
logic/cache_way.sv
logic/way_select.sv
logic/cache_fsm.sv
logic/cache_top.sv
testbench/mem_model.sv
testbench/cache_tb.sv

// ==== testbench/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;
	import cache_pkg::*;

	localparam int SETS          = 16;
	localparam int TAG_SHIFT     = OFFSET_BITS + $clog2(SETS);
	localparam int MEM_WORDS     = 4096;
	localparam int MAX_ENTRIES   = 64;
	localparam int READY_TIMEOUT = 400;

	logic  clk;
	logic  reset;
	logic  cpu_read;
	logic  cpu_write;
	addr_t cpu_addr;
	word_t cpu_wdata;
	logic  cpu_ready;
	word_t cpu_rdata;
	logic  mem_ready;
	word_t mem_rdata;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_addr;
	word_t mem_wdata;

	// stimulus table
	string entry_name [MAX_ENTRIES];
	logic  entry_write [MAX_ENTRIES];
	addr_t entry_addr [MAX_ENTRIES];
	word_t entry_data [MAX_ENTRIES];
	int    entry_count;

	// reference memory and cache state model
	word_t       ref_mem [MEM_WORDS];
	logic        ref_valid [2][SETS];
	logic        ref_dirty [2][SETS];
	logic [31:0] ref_tag [2][SETS];
	logic        ref_lru [SETS];	// names the lru way
	logic [31:0] rng;

	cache_top #(.SETS(SETS)) dut (
		.clk(clk), .reset(reset),
		.cpu_read(cpu_read), .cpu_write(cpu_write), .cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_read(mem_read),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	mem_model #(.WORDS(MEM_WORDS)) main_mem (
		.clk(clk), .reset(reset),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", what, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic add_entry(input string name, input logic write, input addr_t addr,
			input word_t data);
		entry_name[entry_count]  = name;
		entry_write[entry_count] = write;
		entry_addr[entry_count]  = addr;
		entry_data[entry_count]  = data;
		entry_count++;
	endtask

	task automatic wait_ready(input string what, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			#5;
			cycles++;
		end while (!cpu_ready && cycles < READY_TIMEOUT);
		if (!cpu_ready) begin
			$display("timeout, no cpu_ready within %0d cycles for %s", cycles, what);
			$display("TB FAILED");
			$fatal(1, "cache did not respond");
		end
	endtask

	// applies one table entry 5 ns after a rising edge
	task automatic run_entry(input int i);
		string       name;
		addr_t       addr;
		int          set;
		logic [31:0] tag;
		logic        hit;
		logic        way;
		logic        wb;
		addr_t       wb_line;
		int          rd_before;
		int          wr_before;
		int          cycles;
		word_t       rdata;
		name = entry_name[i];
		addr = entry_addr[i];
		set  = (addr >> OFFSET_BITS) % SETS;
		tag  = addr >> TAG_SHIFT;
		hit  = 1'b1;
		wb   = 1'b0;
		if (ref_valid[0][set] && ref_tag[0][set] == tag) begin
			way = 1'b0;
		end else if (ref_valid[1][set] && ref_tag[1][set] == tag) begin
			way = 1'b1;
		end else begin
			hit = 1'b0;
			way = !ref_valid[0][set] ? 1'b0 : (!ref_valid[1][set] ? 1'b1 : ref_lru[set]);
			wb  = ref_valid[way][set] && ref_dirty[way][set];
			wb_line = (ref_tag[way][set] << TAG_SHIFT) | (set << OFFSET_BITS);
		end
		rd_before = main_mem.read_bursts;
		wr_before = main_mem.write_bursts;

		cpu_read  = !entry_write[i];
		cpu_write = entry_write[i];
		cpu_addr  = addr;
		cpu_wdata = entry_data[i];
		wait_ready(name, cycles);
		rdata     = cpu_rdata;

		if (hit) check_value({name, " hit latency"}, 2, cycles);
		check_value({name, " read bursts"}, rd_before + (hit ? 0 : 1), main_mem.read_bursts);
		check_value({name, " write bursts"}, wr_before + wb, main_mem.write_bursts);
		check_value({name, " memory access"}, 0, main_mem.bad_access);
		if (!hit) check_value({name, " refill addr"}, {addr[31:2], 2'b00}, main_mem.last_rd_addr);
		if (wb) begin
			check_value({name, " writeback addr"}, wb_line, main_mem.wr_burst_addr[wr_before]);
			for (int k = 0; k < 4; k++) begin
				check_value($sformatf("%s writeback word %0d", name, k), ref_mem[wb_line + k],
					main_mem.wr_burst_data[wr_before*4 + k]);
			end
		end
		if (!entry_write[i]) check_value({name, " rdata"}, ref_mem[addr], rdata);

		// a miss installs the line clean and then hits
		ref_valid[way][set] = 1'b1;
		ref_tag[way][set]   = tag;
		if (!hit) ref_dirty[way][set] = 1'b0;
		if (entry_write[i]) begin
			ref_dirty[way][set] = 1'b1;
			ref_mem[addr]       = entry_data[i];
		end
		ref_lru[set] = ~way;

		// request stays up through the ready cycle and drops in the next
		@(posedge clk);
		#5;
		check_value({name, " ready pulse"}, 0, cpu_ready);
		cpu_read  = 1'b0;
		cpu_write = 1'b0;
		@(posedge clk);
		#5;
		check_value({name, " no second request"}, 0, cpu_ready);
	endtask

	initial begin
		int tg;
		int st;
		cpu_read    = 1'b0;
		cpu_write   = 1'b0;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		reset       = 1'b0;
		entry_count = 0;
		rng         = 32'h7201_1689;
		for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = i ^ 32'h5a5a_0000;
		for (int s = 0; s < SETS; s++) begin
			ref_valid[0][s] = 1'b0;
			ref_valid[1][s] = 1'b0;
			ref_dirty[0][s] = 1'b0;
			ref_dirty[1][s] = 1'b0;
			ref_tag[0][s]   = '0;
			ref_tag[1][s]   = '0;
			ref_lru[s]      = 1'b0;
		end

		add_entry("read miss", 1'b0, 32'h0000_0105, '0);
		add_entry("read hit", 1'b0, 32'h0000_0107, '0);
		add_entry("write hit", 1'b1, 32'h0000_0106, 32'hcafe_0001);
		add_entry("read after write", 1'b0, 32'h0000_0106, '0);
		// three lines of set 3 with tags 1 to 3
		add_entry("evict fill a", 1'b0, 32'h0000_004c, '0);
		add_entry("evict dirty a", 1'b1, 32'h0000_004d, 32'hdead_beef);
		add_entry("evict fill b", 1'b0, 32'h0000_008c, '0);
		add_entry("evict touch a", 1'b0, 32'h0000_004e, '0);
		add_entry("evict clean b", 1'b0, 32'h0000_00cc, '0);
		add_entry("evict dirty a out", 1'b0, 32'h0000_008f, '0);
		add_entry("evict reread a", 1'b0, 32'h0000_004d, '0);
		for (int k = 0; k < 40; k++) begin
			rng = lcg_step(rng);
			tg  = 1 + rng[25:24];	// four tags over two ways
			st  = rng[17:16];
			add_entry($sformatf("mixed %0d", k), rng[31],
				(tg << TAG_SHIFT) | (st << OFFSET_BITS) | rng[9:8], lcg_step(rng));
			rng = lcg_step(rng);
		end

		for (int c = 0; c < 10; c++) begin
			@(posedge clk);
			#5;
			check_value("reset cpu_ready", 0, cpu_ready);
			check_value("reset mem_read", 0, mem_read);
			check_value("reset mem_write", 0, mem_write);
		end
		reset = 1'b1;
		@(posedge clk);
		#5;
		check_value("after reset cpu_ready", 0, cpu_ready);
		check_value("after reset mem_read", 0, mem_read);
		check_value("after reset mem_write", 0, mem_write);

		for (int i = 0; i < entry_count; i++) begin
			run_entry(i);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/10ps

module mem_model #(
	parameter int WORDS = 4096,
	parameter int MAX_BURSTS = 128
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             mem_read,
	input  logic             mem_write,
	input  cache_pkg::addr_t mem_addr,
	input  cache_pkg::word_t mem_wdata,
	output logic             mem_ready,
	output cache_pkg::word_t mem_rdata
);
	import cache_pkg::*;

	word_t       store [WORDS];
	logic [31:0] rng;
	logic [1:0]  beat;	// word of the current burst
	addr_t       cur_addr;
	int          read_bursts;
	int          write_bursts;
	logic        bad_access;	// unaligned, out of range or moving address
	addr_t       last_rd_addr;
	addr_t       wr_burst_addr [MAX_BURSTS];
	word_t       wr_burst_data [MAX_BURSTS*4];

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			store[i] = i ^ 32'h5a5a_0000;
		end
		rng          = 32'h7201_1689;
		beat         = 2'd0;
		cur_addr     = '0;
		read_bursts  = 0;
		write_bursts = 0;
		bad_access   = 1'b0;
		last_rd_addr = '0;
		mem_ready    = 1'b0;
		mem_rdata    = '0;
	end

	always @(posedge clk) begin
		if (!reset) begin
			beat = 2'd0;
		end else if (mem_ready && (mem_read || mem_write)) begin
			if (beat == 2'd0) begin
				cur_addr = mem_addr;
			end
			if (mem_addr != cur_addr || mem_addr[1:0] != 2'd0 || mem_addr + 3 >= WORDS ||
					(mem_read && mem_write) || write_bursts >= MAX_BURSTS) begin
				bad_access = 1'b1;
			end else if (mem_write) begin
				store[mem_addr + beat] = mem_wdata;
				wr_burst_data[write_bursts*4 + beat] = mem_wdata;
			end
			if (beat == 2'd3) begin	// burst complete
				if (mem_write && !bad_access) begin
					wr_burst_addr[write_bursts] = cur_addr;
					write_bursts++;
				end else if (mem_read) begin
					last_rd_addr = cur_addr;
					read_bursts++;
				end
			end
			beat = beat + 2'd1;
		end
		#5;
		mem_ready = reset && (rng[31:30] != 2'b00);	// about three cycles in four
		rng = lcg_step(rng);
		if (mem_read && mem_addr + beat < WORDS) begin
			mem_rdata = store[mem_addr + beat];
		end else begin
			mem_rdata = '0;
		end
	end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps

module cache_top #(
	parameter int SETS = 16
) (
	input  logic             clk,
	input  logic             reset,
	// processor
	input  logic             cpu_read,
	input  logic             cpu_write,
	input  cache_pkg::addr_t cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	output logic             cpu_ready,
	output cache_pkg::word_t cpu_rdata,
	// main memory
	input  logic             mem_ready,
	input  cache_pkg::word_t mem_rdata,
	output logic             mem_read,
	output logic             mem_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata
);
	import cache_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);
	localparam int TAG_BITS = $bits(addr_t) - OFFSET_BITS - IDX_BITS;

	logic                   hit;
	logic                   hit_way;
	logic                   victim_way;
	word_t                  hit_word;
	logic                   touch;
	logic [TAG_BITS-1:0]    tag;
	logic [IDX_BITS-1:0]    index;
	logic [OFFSET_BITS-1:0] offset;

	way_if #(.SETS(SETS)) way0_bus ();
	way_if #(.SETS(SETS)) way1_bus ();

	cache_way #(.SETS(SETS)) u_way0 (
		.clk   (clk),
		.reset (reset),
		.way   (way0_bus.store)
	);

	cache_way #(.SETS(SETS)) u_way1 (
		.clk   (clk),
		.reset (reset),
		.way   (way1_bus.store)
	);

	way_select #(.SETS(SETS)) u_select (
		.clk        (clk),
		.reset      (reset),
		.way0       (way0_bus.peek),
		.way1       (way1_bus.peek),
		.tag        (tag),
		.index      (index),
		.offset     (offset),
		.touch      (touch),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.hit_word   (hit_word)
	);

	cache_fsm #(.SETS(SETS)) u_fsm (
		.clk        (clk),
		.reset      (reset),
		.cpu_read   (cpu_read),
		.cpu_write  (cpu_write),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_ready  (cpu_ready),
		.cpu_rdata  (cpu_rdata),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.hit_word   (hit_word),
		.tag        (tag),
		.index      (index),
		.offset     (offset),
		.touch      (touch),
		.way0       (way0_bus.ctrl),
		.way1       (way1_bus.ctrl)
	);

endmodule

// ==== logic/cache_fsm.sv ====
`timescale 1ns/10ps

module cache_fsm #(
	parameter int SETS = 16,
	localparam int IDX_BITS = $clog2(SETS),
	localparam int TAG_BITS = $bits(cache_pkg::addr_t) - cache_pkg::OFFSET_BITS - IDX_BITS
) (
	input  logic                              clk,
	input  logic                              reset,
	// processor side
	input  logic                              cpu_read,
	input  logic                              cpu_write,
	input  cache_pkg::addr_t                  cpu_addr,
	input  cache_pkg::word_t                  cpu_wdata,
	output logic                              cpu_ready,
	output cache_pkg::word_t                  cpu_rdata,
	// memory side
	input  logic                              mem_ready,
	input  cache_pkg::word_t                  mem_rdata,
	output logic                              mem_read,
	output logic                              mem_write,
	output cache_pkg::addr_t                  mem_addr,
	output cache_pkg::word_t                  mem_wdata,
	// selector
	input  logic                              hit,
	input  logic                              hit_way,
	input  logic                              victim_way,
	input  cache_pkg::word_t                  hit_word,
	output logic [TAG_BITS-1:0]               tag,
	output logic [IDX_BITS-1:0]               index,
	output logic [cache_pkg::OFFSET_BITS-1:0] offset,
	output logic                              touch,
	// array ports
	way_if.ctrl                               way0,
	way_if.ctrl                               way1
);
	import cache_pkg::*;

	localparam int LINE_BITS = $bits(line_t);

	cache_state_t        state;
	cache_state_t        next_state;
	logic                req;
	logic                last_beat;	// fourth word of a burst
	logic [1:0]          beat_q;
	logic                vic_way_q;
	logic                vic_valid;
	logic                vic_dirty;
	logic                wr_op_q;	// request is a write
	addr_t               addr_q;
	word_t               wdata_q;
	logic [TAG_BITS-1:0] wb_tag_q;
	line_t               wb_buf;	// shifts out low word first
	line_t               fill_buf;	// shifts in from the top
	line_t               merged;
	logic [IDX_BITS-1:0] arr_index;

	// a request is ignored while the ready pulse is out
	assign req       = (cpu_read | cpu_write) & ~cpu_ready;
	assign last_beat = mem_ready && (beat_q == 2'd3);

	assign tag    = addr_q[$bits(addr_t)-1 -: TAG_BITS];
	assign index  = addr_q[OFFSET_BITS +: IDX_BITS];
	assign offset = addr_q[OFFSET_BITS-1:0];

	// victim entry as read from the arrays
	assign vic_valid = victim_way ? way1.rd_valid : way0.rd_valid;
	assign vic_dirty = victim_way ? way1.rd_dirty : way0.rd_dirty;

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (req) next_state = lookup;
			end
			lookup: begin
				if (hit) begin
					next_state = idle;
				end else if (vic_valid && vic_dirty) begin
					next_state = writeback;
				end else begin
					next_state = refill;
				end
			end
			writeback: begin
				if (last_beat) next_state = refill;
			end
			refill: begin
				if (last_beat) next_state = install;
			end
			install: next_state = retry;
			retry:   next_state = lookup;	// arrays show the new line
			default: next_state = idle;
		endcase
	end

	// control registers
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state     <= idle;
			cpu_ready <= 1'b0;
			beat_q    <= 2'd0;
			vic_way_q <= 1'b0;
		end else begin
			state     <= next_state;
			cpu_ready <= (state == lookup) && hit;
			if ((state == writeback || state == refill) && mem_ready) begin
				beat_q <= beat_q + 2'd1;	// wraps to 0 after four words
			end
			if (state == lookup && !hit) begin
				vic_way_q <= victim_way;
			end
		end
	end

	// request latch and line buffers
	always_ff @(posedge clk) begin
		if (state == idle && req) begin
			addr_q  <= cpu_addr;
			wdata_q <= cpu_wdata;
			wr_op_q <= cpu_write & ~cpu_read;	// read wins when both are set
		end
		if (state == lookup && hit) begin
			cpu_rdata <= hit_word;
		end
		if (state == lookup && !hit) begin
			wb_buf   <= victim_way ? way1.rd_line : way0.rd_line;
			wb_tag_q <= victim_way ? way1.rd_tag : way0.rd_tag;
		end
		if (state == writeback && mem_ready) begin
			wb_buf <= wb_buf >> WORD_BITS;
		end
		if (state == refill && mem_ready) begin
			fill_buf <= {mem_rdata, fill_buf[LINE_BITS-1:WORD_BITS]};
		end
	end

	// write hit merge
	always_comb begin
		merged = hit_way ? way1.rd_line : way0.rd_line;
		merged[offset*WORD_BITS +: WORD_BITS] = wdata_q;
	end

	// array index follows the bus in idle so the read starts early
	assign arr_index = (state == idle) ? cpu_addr[OFFSET_BITS +: IDX_BITS] : index;

	assign way0.index = arr_index;
	assign way1.index = arr_index;

	// shared write data, lookup writes a dirty merge, install a clean line
	assign way0.wr_tag   = tag;
	assign way1.wr_tag   = tag;
	assign way0.wr_valid = 1'b1;
	assign way1.wr_valid = 1'b1;
	assign way0.wr_dirty = (state == lookup);
	assign way1.wr_dirty = (state == lookup);
	assign way0.wr_line  = (state == install) ? fill_buf : merged;
	assign way1.wr_line  = (state == install) ? fill_buf : merged;

	assign way0.wr_en = ((state == lookup) && hit && wr_op_q && !hit_way) ||
		((state == install) && !vic_way_q);
	assign way1.wr_en = ((state == lookup) && hit && wr_op_q && hit_way) ||
		((state == install) && vic_way_q);

	assign touch = (state == lookup) && hit;

	// memory bursts, line aligned
	assign mem_write = (state == writeback);
	assign mem_read  = (state == refill);
	assign mem_addr  = (state == writeback) ? {wb_tag_q, index, {OFFSET_BITS{1'b0}}} :
		{tag, index, {OFFSET_BITS{1'b0}}};
	assign mem_wdata = wb_buf[WORD_BITS-1:0];

endmodule

// ==== logic/way_select.sv ====
`timescale 1ns/10ps

module way_select #(
	parameter int SETS = 16,
	localparam int IDX_BITS = $clog2(SETS),
	localparam int TAG_BITS = $bits(cache_pkg::addr_t) - cache_pkg::OFFSET_BITS - IDX_BITS
) (
	input  logic                           clk,
	input  logic                           reset,
	way_if.peek                            way0,
	way_if.peek                            way1,
	input  logic [TAG_BITS-1:0]            tag,	// latched request tag
	input  logic [IDX_BITS-1:0]            index,
	input  logic [cache_pkg::OFFSET_BITS-1:0] offset,
	input  logic                           touch,
	output logic                           hit,
	output logic                           hit_way,
	output logic                           victim_way,
	output cache_pkg::word_t               hit_word
);
	import cache_pkg::*;

	logic            hit0;
	logic            hit1;
	line_t           hit_line;
	logic [SETS-1:0] lru_q;	// per set, names the least recently used way

	// tag compare per way
	assign hit0 = way0.rd_valid && (way0.rd_tag == tag);
	assign hit1 = way1.rd_valid && (way1.rd_tag == tag);

	assign hit     = hit0 | hit1;
	assign hit_way = hit1 & ~hit0;	// way 0 wins a double match

	// word pick by block offset
	assign hit_line = hit_way ? way1.rd_line : way0.rd_line;
	assign hit_word = hit_line[offset*WORD_BITS +: WORD_BITS];

	// recency table
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lru_q <= '0;
		end else if (touch) begin
			lru_q[index] <= ~hit_way;	// the other way becomes lru
		end
	end

	// empty ways fill first, then lru
	always_comb begin
		if (!way0.rd_valid) begin
			victim_way = 1'b0;
		end else if (!way1.rd_valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[index];
		end
	end

endmodule

// ==== logic/cache_way.sv ====
`timescale 1ns/10ps

module cache_way #(
	parameter int SETS = 16
) (
	input logic clk,
	input logic reset,
	way_if.store way
);
	import cache_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);
	localparam int TAG_BITS = $bits(addr_t) - OFFSET_BITS - IDX_BITS;

	logic [TAG_BITS-1:0] tag_mem [SETS];
	line_t               line_mem [SETS];
	logic [SETS-1:0]     dirty_mem;
	logic [SETS-1:0]     valid_q;	// only valid bits are cleared
	logic [IDX_BITS-1:0] rd_idx;	// registered read address

	// storage arrays, all fields written together
	always_ff @(posedge clk) begin
		rd_idx <= way.index;
		if (way.wr_en) begin
			tag_mem[way.index]   <= way.wr_tag;
			line_mem[way.index]  <= way.wr_line;
			dirty_mem[way.index] <= way.wr_dirty;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
		end else if (way.wr_en) begin
			valid_q[way.index] <= way.wr_valid;
		end
	end

	// read data one cycle after the index
	assign way.rd_tag   = tag_mem[rd_idx];
	assign way.rd_line  = line_mem[rd_idx];
	assign way.rd_dirty = dirty_mem[rd_idx];
	assign way.rd_valid = valid_q[rd_idx];

endmodule

// ==== logic/way_if.sv ====
`timescale 1ns/10ps

interface way_if #(
	parameter int SETS = 16
) ();
	import cache_pkg::*;

	localparam int IDX_BITS = $clog2(SETS);
	localparam int TAG_BITS = $bits(addr_t) - OFFSET_BITS - IDX_BITS;

	logic [IDX_BITS-1:0] index;	// read and write set

	// write side, taken at the clock edge
	logic                wr_en;
	logic [TAG_BITS-1:0] wr_tag;
	logic                wr_valid;
	logic                wr_dirty;
	line_t               wr_line;

	// read side, entry at the index of the previous edge
	logic [TAG_BITS-1:0] rd_tag;
	logic                rd_valid;
	logic                rd_dirty;
	line_t               rd_line;

	modport ctrl (
		output index, wr_en, wr_tag, wr_valid, wr_dirty, wr_line,
		input  rd_tag, rd_valid, rd_dirty, rd_line
	);

	modport store (
		input  index, wr_en, wr_tag, wr_valid, wr_dirty, wr_line,
		output rd_tag, rd_valid, rd_dirty, rd_line
	);

	modport peek (
		input rd_tag, rd_valid, rd_dirty, rd_line
	);

endinterface

// ==== logic/cache_pkg.sv ====
package cache_pkg;

	// data and address geometry
	localparam int WORD_BITS      = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_BITS    = 2;	// word offset inside a line

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [31:0] addr_t;	// word address, not byte
	typedef logic [WORD_BITS*WORDS_PER_LINE-1:0] line_t;	// word 0 in the low bits

	// controller states
	typedef enum logic [2:0] {
		idle      = 3'd0,
		lookup    = 3'd1,
		writeback = 3'd2,	// dirty victim out to memory
		refill    = 3'd3,	// four word burst in
		install   = 3'd4,
		retry     = 3'd5
	} cache_state_t;

endpackage
